// File: src/raster_pkg.sv
// Raster package holding fixed-point widths, coordinate types and iterator states
package raster_pkg;

    // Fixed-point format shared by positions and colours
    parameter int SIGFIG = 24;  // Bits in a coordinate or colour channel
    parameter int RADIX  = 10;  // Fraction bits, integer part sits above

    // Triangle shape
    parameter int VERTS  = 3;   // Vertices per triangle
    parameter int AXIS   = 3;   // x, y, z per vertex
    parameter int COLORS = 3;   // Colour channels

    // Signed position, integer part in [SIGFIG-1:RADIX]
    typedef logic signed [SIGFIG-1:0] coord_t;

    // Unsigned colour channel
    typedef logic [SIGFIG-1:0] color_t;

    // One-hot multisample code
    //   1000  1x, one pixel interval
    //   0100  4x, half pixel interval
    //   0010  16x, quarter pixel interval
    //   0001  64x, eighth pixel interval
    typedef logic [3:0] ss_code_t;

    // Controller states
    typedef enum logic {
        WAIT_ST,  // Idle, accepting a new box
        TEST_ST   // Walking the box
    } iter_state_t;

    // Width for look-ahead sums over a group of lanes
    // Leaves room for SAMPLES intervals past a coordinate without wrap
    function automatic int ext_width(int samples);
        return SIGFIG + $clog2(samples + 1);
    endfunction

endpackage

// File: src/iter_if.sv
// Iterator bus carrying box, step commands and group position between control and generator
`timescale 1ns/1ps

interface iter_if;
    import raster_pkg::*;

    // Box as seen by the generator
    coord_t box_min_x;
    coord_t box_min_y;
    coord_t box_max_x;
    coord_t box_max_y;

    // Step commands from the controller
    logic   load;        // Start at bottom-left corner, one cycle
    logic   step_right;  // Next group along the row
    logic   step_up;     // Back to min x, one row up
    logic   finish;      // Box done, drop all lanes

    // Group position fed back for edge checks
    coord_t last_x;      // x of the group's last lane
    coord_t cur_y;       // Row y
    coord_t step;        // Interval latched for this box

    modport ctrl (
        output box_min_x, box_min_y, box_max_x, box_max_y,
        output load, step_right, step_up, finish,
        input  last_x, cur_y, step
    );

    modport gen (
        input  box_min_x, box_min_y, box_max_x, box_max_y,
        input  load, step_right, step_up, finish,
        output last_x, cur_y, step
    );

endinterface

// File: src/iter_ctrl.sv
// Iterator controller with wait/test FSM, box register, edge detection and accept level
`timescale 1ns/1ps

module iter_ctrl #(
    parameter int SAMPLES = 2  // Lanes per group
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               tri_valid,  // Level, new box offered
    input  raster_pkg::coord_t box_min_x,
    input  raster_pkg::coord_t box_min_y,
    input  raster_pkg::coord_t box_max_x,
    input  raster_pkg::coord_t box_max_y,
    output logic               accept,     // High while waiting for a box
    iter_if.ctrl               bus
);
    import raster_pkg::*;

    localparam int XW = ext_width(SAMPLES);  // Sum width, no wrap past the box

    iter_state_t state;
    iter_state_t next_state;

    coord_t min_x_q;  // Box held for the walk
    coord_t min_y_q;
    coord_t max_x_q;
    coord_t max_y_q;

    logic take;        // Box taken this cycle
    logic right_edge;  // Next group would start past max x
    logic top_edge;    // Next row would start past max y

    // Moore output, upstream stalls while testing
    assign accept = (state == WAIT_ST);
    assign take   = accept & tri_valid;

    assign bus.load = take;

    // Incoming box bypasses the register on the load cycle
    assign bus.box_min_x = take ? box_min_x : min_x_q;
    assign bus.box_min_y = take ? box_min_y : min_y_q;
    assign bus.box_max_x = take ? box_max_x : max_x_q;
    assign bus.box_max_y = take ? box_max_y : max_y_q;

    // Edges judged one interval ahead, so off-grid maxima end the walk on the last in-grid point
    assign right_edge = (XW'(bus.last_x) + XW'(bus.step)) > XW'(max_x_q);
    assign top_edge   = (XW'(bus.cur_y) + XW'(bus.step)) > XW'(max_y_q);

    always_comb begin
        next_state     = state;
        bus.step_right = 1'b0;
        bus.step_up    = 1'b0;
        bus.finish     = 1'b0;
        case (state)
            WAIT_ST: begin
                if (take) begin
                    next_state = TEST_ST;  // First group shows next cycle
                end
            end
            TEST_ST: begin
                if (right_edge && top_edge) begin
                    bus.finish = 1'b1;     // Top right group is out now
                    next_state = WAIT_ST;
                end else if (right_edge) begin
                    bus.step_up = 1'b1;    // Wrap to next row
                end else begin
                    bus.step_right = 1'b1;
                end
            end
            default: next_state = WAIT_ST;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= WAIT_ST;
        end else begin
            state <= next_state;
        end
    end

    // Box stays put for the whole walk
    always_ff @(posedge clk) begin
        if (take) begin
            min_x_q <= box_min_x;
            min_y_q <= box_min_y;
            max_x_q <= box_max_x;
            max_y_q <= box_max_y;
        end
    end

endmodule

// File: src/sample_gen.sv
// Sample generator decoding the interval and stepping a group of lanes across the box
`timescale 1ns/1ps

module sample_gen #(
    parameter int SAMPLES = 2  // Lanes per group
) (
    input  logic                 clk,
    input  logic                 rst,
    input  raster_pkg::ss_code_t subsample,                  // One-hot multisample code
    iter_if.gen                  bus,
    output raster_pkg::coord_t   sample_x [SAMPLES-1:0],     // Lane x
    output raster_pkg::coord_t   sample_y [SAMPLES-1:0],     // Lane y, one row per group
    output logic                 sample_valid [SAMPLES-1:0]  // Lane inside the box
);
    import raster_pkg::*;

    localparam int XW = ext_width(SAMPLES);  // Lane x before truncation

    coord_t interval;  // Decoded from subsample
    coord_t step_q;    // Interval for the current box
    coord_t row_y;     // Current row

    coord_t nx_org;    // Next group's first lane x
    coord_t nx_y;
    coord_t nx_step;
    logic   move;      // Any step this cycle

    logic signed [XW-1:0] lane_x [SAMPLES-1:0];  // Next lane x, wide for the bound check

    // One-hot code to interval
    // Bit 3 lands on the integer LSB, each lower bit halves the interval
    assign interval = coord_t'(subsample) << (RADIX - 3);

    assign move = bus.load | bus.step_right | bus.step_up;

    always_comb begin
        nx_org  = sample_x[0];
        nx_y    = row_y;
        nx_step = step_q;
        if (bus.load) begin
            nx_org  = bus.box_min_x;  // Bottom-left corner
            nx_y    = bus.box_min_y;
            nx_step = interval;
        end else if (bus.step_up) begin
            nx_org = bus.box_min_x;
            nx_y   = row_y + step_q;
        end else if (bus.step_right) begin
            nx_org = sample_x[SAMPLES-1] + step_q;  // One interval past the last lane
        end

        // Lanes one interval apart in x
        lane_x[0] = XW'(nx_org);
        for (int i = 1; i < SAMPLES; i++) begin
            lane_x[i] = lane_x[i-1] + XW'(nx_step);
        end
    end

    // Positions only change on a step
    always_ff @(posedge clk) begin
        if (move) begin
            step_q <= nx_step;
            row_y  <= nx_y;
            for (int i = 0; i < SAMPLES; i++) begin
                sample_x[i] <= coord_t'(lane_x[i]);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < SAMPLES; i++) begin
                sample_valid[i] <= 1'b0;
            end
        end else if (bus.finish) begin
            for (int i = 0; i < SAMPLES; i++) begin
                sample_valid[i] <= 1'b0;  // Walk over
            end
        end else if (move) begin
            for (int i = 0; i < SAMPLES; i++) begin
                sample_valid[i] <= (lane_x[i] <= XW'(bus.box_max_x));  // Trailing lanes past max x drop
            end
        end
    end

    // All lanes share the row
    always_comb begin
        for (int i = 0; i < SAMPLES; i++) begin
            sample_y[i] = row_y;
        end
    end

    // Group position back to the controller
    assign bus.last_x = sample_x[SAMPLES-1];
    assign bus.cur_y  = row_y;
    assign bus.step   = step_q;

endmodule

// File: src/tri_hold.sv
// Triangle hold register capturing vertices and colour while its box is walked
`timescale 1ns/1ps

module tri_hold (
    input  logic               clk,
    input  logic               rst,
    input  logic               load,  // Box taken
    input  raster_pkg::coord_t tri_in    [raster_pkg::VERTS-1:0][raster_pkg::AXIS-1:0],
    input  raster_pkg::color_t color_in  [raster_pkg::COLORS-1:0],
    output raster_pkg::coord_t tri_out   [raster_pkg::VERTS-1:0][raster_pkg::AXIS-1:0],
    output raster_pkg::color_t color_out [raster_pkg::COLORS-1:0]
);

    // Vertices, held until the next box is taken
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            foreach (tri_out[v, a]) begin
                tri_out[v][a] <= '0;
            end
        end else if (load) begin
            foreach (tri_out[v, a]) begin
                tri_out[v][a] <= tri_in[v][a];  // Later tri_in changes ignored mid-walk
            end
        end
    end

    // Colour travels with the same triangle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            foreach (color_out[c]) begin
                color_out[c] <= '0;
            end
        end else if (load) begin
            foreach (color_out[c]) begin
                color_out[c] <= color_in[c];
            end
        end
    end

endmodule

// File: src/sample_iterator.sv
// Sample-test iterator walking a triangle's bounding box a group of samples per cycle
`timescale 1ns/1ps

module sample_iterator #(
    parameter int SAMPLES = 2  // Lanes per group
) (
    input  logic                 clk,
    input  logic                 rst,

    // Triangle and box from the bounding-box stage
    input  logic                 tri_valid,
    input  raster_pkg::coord_t   tri_in    [raster_pkg::VERTS-1:0][raster_pkg::AXIS-1:0],
    input  raster_pkg::color_t   color_in  [raster_pkg::COLORS-1:0],
    input  raster_pkg::coord_t   box_min_x,
    input  raster_pkg::coord_t   box_min_y,
    input  raster_pkg::coord_t   box_max_x,
    input  raster_pkg::coord_t   box_max_y,
    input  raster_pkg::ss_code_t subsample,  // Multisample mode

    output logic                 accept,     // Low holds the upstream stage

    // Triangle and samples to the sample test
    output raster_pkg::coord_t   tri_out   [raster_pkg::VERTS-1:0][raster_pkg::AXIS-1:0],
    output raster_pkg::color_t   color_out [raster_pkg::COLORS-1:0],
    output raster_pkg::coord_t   sample_x     [SAMPLES-1:0],
    output raster_pkg::coord_t   sample_y     [SAMPLES-1:0],
    output logic                 sample_valid [SAMPLES-1:0]
);

    iter_if bus ();  // Controller to generator

    // FSM, box register and edge detection
    iter_ctrl #(
        .SAMPLES (SAMPLES)
    ) u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .tri_valid (tri_valid),
        .box_min_x (box_min_x),
        .box_min_y (box_min_y),
        .box_max_x (box_max_x),
        .box_max_y (box_max_y),
        .accept    (accept),
        .bus       (bus.ctrl)
    );

    // Lane positions and valids
    sample_gen #(
        .SAMPLES (SAMPLES)
    ) u_gen (
        .clk          (clk),
        .rst          (rst),
        .subsample    (subsample),
        .bus          (bus.gen),
        .sample_x     (sample_x),
        .sample_y     (sample_y),
        .sample_valid (sample_valid)
    );

    // Triangle data, captured on the same load as the box
    tri_hold u_hold (
        .clk       (clk),
        .rst       (rst),
        .load      (bus.load),
        .tri_in    (tri_in),
        .color_in  (color_in),
        .tri_out   (tri_out),
        .color_out (color_out)
    );

endmodule

// File: dv/tb_clock.sv
// Testbench clock source, free running from time zero
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 8  // Full clock period
) (
    output logic clk
);

    initial begin
        clk = 1'b0;  // First rising edge half a period in
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

// File: dv/tb_checker.sv
// Testbench monitor predicting sample groups for each accepted box and comparing every cycle
`timescale 1ns/1ps

module tb_checker #(
    parameter int SAMPLES = 2  // Lanes per group
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 tri_valid,
    input  logic                 accept,
    input  raster_pkg::coord_t   box_min_x,
    input  raster_pkg::coord_t   box_min_y,
    input  raster_pkg::coord_t   box_max_x,
    input  raster_pkg::coord_t   box_max_y,
    input  raster_pkg::ss_code_t subsample,
    input  raster_pkg::coord_t   tri_in       [raster_pkg::VERTS-1:0][raster_pkg::AXIS-1:0],
    input  raster_pkg::color_t   color_in     [raster_pkg::COLORS-1:0],
    input  raster_pkg::coord_t   tri_out      [raster_pkg::VERTS-1:0][raster_pkg::AXIS-1:0],
    input  raster_pkg::color_t   color_out    [raster_pkg::COLORS-1:0],
    input  raster_pkg::coord_t   sample_x     [SAMPLES-1:0],
    input  raster_pkg::coord_t   sample_y     [SAMPLES-1:0],
    input  logic                 sample_valid [SAMPLES-1:0],
    output int                   errors,   // Failed checks so far
    output int                   pending   // Groups the DUT still owes
);
    import raster_pkg::*;

    // One expected output cycle
    typedef struct packed {
        coord_t [SAMPLES-1:0] x;
        coord_t               y;
        logic [SAMPLES-1:0]   valid;
    } group_t;

    group_t exp_q [$];                         // In walk order
    coord_t held_tri   [VERTS-1:0][AXIS-1:0];  // Triangle of the box in progress
    color_t held_color [COLORS-1:0];
    int     err_count = 0;
    int     queued    = 0;
    logic   any_lane;                          // Some lane valid this cycle

    assign errors  = err_count;
    assign pending = queued;

    always_comb begin
        any_lane = 1'b0;
        for (int i = 0; i < SAMPLES; i++) begin
            any_lane |= sample_valid[i];
        end
    end

    // Sample interval per multisample mode
    function automatic coord_t interval_for(ss_code_t code);
        case (code)
            4'b1000: return coord_t'(1 << RADIX);        // Whole pixel
            4'b0100: return coord_t'(1 << (RADIX - 1));  // Half
            4'b0010: return coord_t'(1 << (RADIX - 2));  // Quarter
            default: return coord_t'(1 << (RADIX - 3));  // Eighth
        endcase
    endfunction

    // Reference model, queues every group of one box
    // Columns and rows are counted by floor, so off-grid maxima drop the partial interval
    function automatic void expect_walk(coord_t min_x, coord_t min_y, coord_t max_x,
                                        coord_t max_y, ss_code_t code);
        int     step;
        int     cols;
        int     rows;
        int     groups;
        int     k;
        group_t g;
        step   = int'(interval_for(code));
        cols   = (int'(max_x) - int'(min_x)) / step + 1;
        rows   = (int'(max_y) - int'(min_y)) / step + 1;
        groups = (cols + SAMPLES - 1) / SAMPLES;  // Last group may be part full
        for (int r = 0; r < rows; r++) begin
            for (int gi = 0; gi < groups; gi++) begin
                for (int i = 0; i < SAMPLES; i++) begin
                    k          = gi * SAMPLES + i;                 // Column index of the lane
                    g.x[i]     = coord_t'(int'(min_x) + k * step);
                    g.valid[i] = (k < cols);
                end
                g.y = coord_t'(int'(min_y) + r * step);
                exp_q.push_back(g);
            end
        end
    endfunction

    task automatic check_field(string name, logic [SIGFIG-1:0] got, logic [SIGFIG-1:0] want);
        if (got !== want) begin
            err_count++;
            $display("FAIL t=%0t %s got %h exp %h", $time, name, got, want);
        end
    endtask

    task automatic compare_group(group_t g);
        for (int i = 0; i < SAMPLES; i++) begin
            check_field($sformatf("sample_valid[%0d]", i), SIGFIG'(sample_valid[i]),
                        SIGFIG'(g.valid[i]));
            check_field($sformatf("sample_x[%0d]", i), sample_x[i], g.x[i]);
            if (g.valid[i]) begin
                check_field($sformatf("sample_y[%0d]", i), sample_y[i], g.y);  // Only live lanes
            end
        end
        foreach (held_tri[v, a]) begin
            check_field($sformatf("tri_out[%0d][%0d]", v, a), tri_out[v][a], held_tri[v][a]);
        end
        foreach (held_color[c]) begin
            check_field($sformatf("color_out[%0d]", c), color_out[c], held_color[c]);
        end
    endtask

    // Pre-edge values describe the cycle that just ended
    always @(posedge clk) begin : compare_proc
        group_t g;
        if (!rst) begin
            // Accept high exactly while nothing is owed
            check_field("accept", SIGFIG'(accept), SIGFIG'(exp_q.size() == 0));
            if (any_lane || exp_q.size() != 0) begin
                if (exp_q.size() == 0) begin
                    err_count++;
                    $display("Sample lanes valid at %0t with no box in progress", $time);
                end else if (!any_lane) begin
                    err_count++;
                    $display("Expected sample group missing at %0t, %0d groups still owed",
                             $time, exp_q.size());
                end else begin
                    g = exp_q.pop_front();
                    compare_group(g);
                end
            end
            if (accept && tri_valid) begin
                expect_walk(box_min_x, box_min_y, box_max_x, box_max_y, subsample);
                held_tri   = tri_in;    // Data the walk must carry
                held_color = color_in;
            end
            queued = exp_q.size();
        end
    end

endmodule

// File: dv/tb_top.sv
// Testbench top sending directed and random boxes through the sample iterator
`timescale 1ns/1ps

module tb_top;
    import raster_pkg::*;

    localparam int SAMPLES    = 2;
    localparam int NBOX       = 24;  // Four directed boxes, twenty random
    localparam int RST_CYCLES = 5;

    logic     clk;
    logic     rst;
    logic     tri_valid;
    logic     accept;
    coord_t   tri_in    [VERTS-1:0][AXIS-1:0];
    color_t   color_in  [COLORS-1:0];
    coord_t   tri_out   [VERTS-1:0][AXIS-1:0];
    color_t   color_out [COLORS-1:0];
    coord_t   box_min_x;
    coord_t   box_min_y;
    coord_t   box_max_x;
    coord_t   box_max_y;
    ss_code_t subsample;
    coord_t   sample_x     [SAMPLES-1:0];
    coord_t   sample_y     [SAMPLES-1:0];
    logic     sample_valid [SAMPLES-1:0];
    int       errors;
    int       pending;

    // Box table filled before reset is released
    coord_t   b_min_x [NBOX];
    coord_t   b_min_y [NBOX];
    coord_t   b_max_x [NBOX];
    coord_t   b_max_y [NBOX];
    ss_code_t b_code  [NBOX];

    logic [31:0] lfsr;
    int          cycles = 0;
    int          limit  = 0;   // Cycle budget for the whole run
    int          passed = 0;
    int          failed = 0;

    tb_clock clkgen (.clk(clk));

    sample_iterator #(
        .SAMPLES (SAMPLES)
    ) dut (
        .clk          (clk),
        .rst          (rst),
        .tri_valid    (tri_valid),
        .tri_in       (tri_in),
        .color_in     (color_in),
        .box_min_x    (box_min_x),
        .box_min_y    (box_min_y),
        .box_max_x    (box_max_x),
        .box_max_y    (box_max_y),
        .subsample    (subsample),
        .accept       (accept),
        .tri_out      (tri_out),
        .color_out    (color_out),
        .sample_x     (sample_x),
        .sample_y     (sample_y),
        .sample_valid (sample_valid)
    );

    tb_checker #(
        .SAMPLES (SAMPLES)
    ) chk (
        .clk          (clk),
        .rst          (rst),
        .tri_valid    (tri_valid),
        .accept       (accept),
        .box_min_x    (box_min_x),
        .box_min_y    (box_min_y),
        .box_max_x    (box_max_x),
        .box_max_y    (box_max_y),
        .subsample    (subsample),
        .tri_in       (tri_in),
        .color_in     (color_in),
        .tri_out      (tri_out),
        .color_out    (color_out),
        .sample_x     (sample_x),
        .sample_y     (sample_y),
        .sample_valid (sample_valid),
        .errors       (errors),
        .pending      (pending)
    );

    // Galois LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);  // One step per bit
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic set_box(int k, ss_code_t code, coord_t x0, coord_t y0, int dx, int dy);
        b_code[k]  = code;
        b_min_x[k] = x0;
        b_min_y[k] = y0;
        b_max_x[k] = coord_t'(int'(x0) + dx);
        b_max_y[k] = coord_t'(int'(y0) + dy);
    endtask

    // Walk length of one box for the cycle budget
    function automatic int group_count(int k);
        int step;
        int cols;
        int rows;
        case (b_code[k])
            4'b1000: step = 1 << RADIX;
            4'b0100: step = 1 << (RADIX - 1);
            4'b0010: step = 1 << (RADIX - 2);
            default: step = 1 << (RADIX - 3);
        endcase
        cols = (int'(b_max_x[k]) - int'(b_min_x[k])) / step + 1;
        rows = (int'(b_max_y[k]) - int'(b_min_y[k])) / step + 1;
        return rows * ((cols + SAMPLES - 1) / SAMPLES);
    endfunction

    // Box from the table with a fresh random triangle and colour
    task automatic drive_box(int k);
        box_min_x = b_min_x[k];
        box_min_y = b_min_y[k];
        box_max_x = b_max_x[k];
        box_max_y = b_max_y[k];
        subsample = b_code[k];
        foreach (tri_in[v, a]) begin
            tri_in[v][a] = coord_t'(rand_bits(SIGFIG));
        end
        foreach (color_in[c]) begin
            color_in[c] = color_t'(rand_bits(SIGFIG));
        end
    endtask

    // Runs from a falling edge to the falling edge after the take
    task automatic send_box(int k, bit hold);
        drive_box(k);
        tri_valid = 1'b1;
        while (!accept) begin
            @(negedge clk);
        end
        @(negedge clk);     // Taken on the rising edge just passed
        if (!hold) begin
            tri_valid = 1'b0;
        end
    endtask

    task automatic wait_done();
        while (pending != 0 || !accept) begin
            @(negedge clk);
        end
        @(negedge clk);     // Idle cycle after the walk goes through the checker
    endtask

    task automatic end_test(string name, int err_before);
        if (errors == err_before) begin
            passed++;
            $display("%s: ok", name);
        end else begin
            failed++;
            $display("%s: %0d errors", name, errors - err_before);
        end
    endtask

    // Watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout after %0d cycles with boxes still unfinished", limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        int       e;
        int       dx;
        int       dy;
        ss_code_t code;
        lfsr      = 32'h74ad4132;
        rst       = 1'b1;
        tri_valid = 1'b0;
        box_min_x = '0;
        box_min_y = '0;
        box_max_x = '0;
        box_max_y = '0;
        subsample = 4'b1000;
        foreach (tri_in[v, a]) begin
            tri_in[v][a] = '0;
        end
        foreach (color_in[c]) begin
            color_in[c] = '0;
        end

        set_box(0, 4'b1000, coord_t'(5 << RADIX), coord_t'(3 << RADIX), 1023, 1023);
        set_box(1, 4'b0100, coord_t'(10 << RADIX), coord_t'(7 << RADIX), 4 * 512, 512);
        set_box(2, 4'b0010, coord_t'((20 << RADIX) + 64), coord_t'(2 << RADIX),
                4 * 256 + 100, 2 * 256 + 37);  // Both maxima off the grid
        set_box(3, 4'b1000, coord_t'(1 << RADIX), coord_t'(9 << RADIX), 2 * 1024, 1024);
        for (int k = 4; k < NBOX; k++) begin
            code = (rand_bits(1) != 32'd0) ? 4'b0001 : 4'b1000;
            dx   = int'(rand_bits(code[0] ? 10 : 12));  // Up to eight 64x columns or four 1x
            dy   = int'(rand_bits(code[0] ? 9 : 11));
            set_box(k, code, coord_t'(rand_bits(18)), coord_t'(rand_bits(18)), dx, dy);
        end
        limit = RST_CYCLES + 100;
        for (int k = 0; k < NBOX; k++) begin
            limit += group_count(k) + 2;
        end

        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        e = errors;
        send_box(0, 1'b0);
        wait_done();
        end_test("test 1 reset and single 1x pixel", e);

        e = errors;
        send_box(1, 1'b0);
        wait_done();
        end_test("test 2 4x box five columns by two rows", e);

        e = errors;
        send_box(2, 1'b0);
        wait_done();
        end_test("test 3 16x box with off-grid maximum", e);

        // New triangle offered mid-walk must be ignored
        e = errors;
        send_box(3, 1'b0);
        drive_box(NBOX - 1);
        tri_valid = 1'b1;
        @(negedge clk);
        tri_valid = 1'b0;
        wait_done();
        end_test("test 4 triangle held through the walk", e);

        e = errors;
        for (int k = 4; k < NBOX; k++) begin
            send_box(k, 1'b1);  // tri_valid stays high between boxes
        end
        tri_valid = 1'b0;
        wait_done();
        end_test("test 5 twenty random boxes back to back", e);

        $display("Summary: %0d passed, %0d failed, %0d check errors", passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: sample_iterator.f
src/raster_pkg.sv
src/iter_if.sv
src/iter_ctrl.sv
src/sample_gen.sv
src/tri_hold.sv
src/sample_iterator.sv
dv/tb_clock.sv
dv/tb_checker.sv
dv/tb_top.sv

// File: Makefile
# Verilator build and run for the sample iterator testbench

TOP := tb_top

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sample_iterator.f $(wildcard src/*.sv dv/*.sv)
	verilator --binary --timing -j 0 -f sample_iterator.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

lint:
	verilator --lint-only --timing -f sample_iterator.f --top-module $(TOP)

clean:
	rm -rf obj_dir
